//--- include/rs_validator_cfg.svh
`ifndef RS_VALIDATOR_CFG_SVH
`define RS_VALIDATOR_CFG_SVH

// ==================
// Datapath widths
// ==================

// Operands, PC values and store data
`define RSV_DATA_W 32

// Physical register file has 64 entries
`define RSV_PREG_W 6

// ==================
// Decode fields
// ==================

// Control signal bundle from decode, carried opaque through the RS
`define RSV_CTRL_W 11

// Branch condition select
`define RSV_BSEL_W 3

// Producer tag for an operand that is still waiting on a result
`define RSV_TAG_W 3

`endif

//--- rtl/rs_validator_pkg.sv
`default_nettype none

`include "rs_validator_cfg.svh"

package rs_validator_pkg;

   // ==================
   // Issue toward execute
   // ==================

   // One issue bundle leaving an RS copy
   typedef struct packed {
      logic                   issue_valid;
      logic [`RSV_DATA_W-1:0] data_a;
      logic [`RSV_DATA_W-1:0] data_b;
      logic [`RSV_CTRL_W-1:0] control_signals;
      logic [`RSV_PREG_W-1:0] rd_phys_addr;
      logic [`RSV_DATA_W-1:0] pc;
      // PC the predictor saw, needed to resolve the branch
      logic [`RSV_DATA_W-1:0] pc_value_at_prediction;
      logic [`RSV_BSEL_W-1:0] branch_sel;
      logic                   branch_prediction;
      logic [`RSV_DATA_W-1:0] store_data;
   } rs_exec_bundle_t;

   // ==================
   // RS register state
   // ==================

   // Internal registers of one RS copy
   typedef struct packed {
      logic                   enable;
      logic                   occupied;
      logic [`RSV_CTRL_W-1:0] control_signals;
      logic [`RSV_DATA_W-1:0] pc;
      logic [`RSV_PREG_W-1:0] rd_phys_addr;
      logic [`RSV_DATA_W-1:0] pc_value_at_prediction;
      logic [`RSV_BSEL_W-1:0] branch_sel;
      logic                   branch_prediction;
      logic [`RSV_DATA_W-1:0] store_data;
      // Source operands, each with the tag of its pending producer
      logic [`RSV_DATA_W-1:0] operand_a_data;
      logic [`RSV_TAG_W-1:0]  operand_a_tag;
      logic [`RSV_DATA_W-1:0] operand_b_data;
      logic [`RSV_TAG_W-1:0]  operand_b_tag;
   } rs_internal_t;

endpackage

`default_nettype wire

//--- rtl/tmr_voter.sv
`timescale 1ns/1ps
`default_nettype none

// Majority voter for one field of three redundant copies
module tmr_voter #(
   parameter int WIDTH = 1
) (
   input  wire logic             secure_mode_i,
   input  wire logic [WIDTH-1:0] copy_0_i,
   input  wire logic [WIDTH-1:0] copy_1_i,
   input  wire logic [WIDTH-1:0] copy_2_i,
   output logic      [WIDTH-1:0] voted_o,
   output logic                  mismatch_o,
   output logic                  fatal_o
);

   // ==================
   // Pairwise compare
   // ==================

   logic eq_01;
   logic eq_02;
   logic eq_12;

   assign eq_01 = (copy_0_i == copy_1_i);
   assign eq_02 = (copy_0_i == copy_2_i);
   assign eq_12 = (copy_1_i == copy_2_i);

   // ==================
   // Vote
   // ==================

   // Copy 0 is the default, both when voting is off and when no two copies agree
   always_comb begin
      voted_o    = copy_0_i;
      mismatch_o = 1'b0;
      fatal_o    = 1'b0;
      if (secure_mode_i) begin
         // Copy 0 loses only when copies 1 and 2 agree against it
         if (eq_12 && !eq_01) begin
            voted_o = copy_1_i;
         end
         // Any disagreement at all
         mismatch_o = !(eq_01 && eq_12);
         // No majority exists
         fatal_o    = !eq_01 && !eq_02 && !eq_12;
      end
   end

endmodule

`default_nettype wire

//--- rtl/exec_vote.sv
`timescale 1ns/1ps
`default_nettype none

`include "rs_validator_cfg.svh"

// Votes the issue bundles of the three RS copies field by field
module exec_vote (
   input  wire logic                             secure_mode_i,
   input  wire rs_validator_pkg::rs_exec_bundle_t exec_in_0_i,
   input  wire rs_validator_pkg::rs_exec_bundle_t exec_in_1_i,
   input  wire rs_validator_pkg::rs_exec_bundle_t exec_in_2_i,
   output rs_validator_pkg::rs_exec_bundle_t      exec_out_0_o,
   output rs_validator_pkg::rs_exec_bundle_t      exec_out_1_o,
   output rs_validator_pkg::rs_exec_bundle_t      exec_out_2_o,
   output logic                                  mismatch_o,
   output logic                                  fatal_o
);

   rs_validator_pkg::rs_exec_bundle_t voted;

   // One flag bit per bundle field
   logic [9:0] mm_v;
   logic [9:0] fatal_v;

   // ==================
   // Field voters
   // ==================

   tmr_voter #(.WIDTH(1)) u_issue_valid (
      .secure_mode_i(secure_mode_i), .copy_0_i(exec_in_0_i.issue_valid),
      .copy_1_i(exec_in_1_i.issue_valid), .copy_2_i(exec_in_2_i.issue_valid),
      .voted_o(voted.issue_valid), .mismatch_o(mm_v[0]), .fatal_o(fatal_v[0])
   );

   tmr_voter #(.WIDTH(`RSV_DATA_W)) u_data_a (
      .secure_mode_i(secure_mode_i), .copy_0_i(exec_in_0_i.data_a),
      .copy_1_i(exec_in_1_i.data_a), .copy_2_i(exec_in_2_i.data_a),
      .voted_o(voted.data_a), .mismatch_o(mm_v[1]), .fatal_o(fatal_v[1])
   );

   tmr_voter #(.WIDTH(`RSV_DATA_W)) u_data_b (
      .secure_mode_i(secure_mode_i), .copy_0_i(exec_in_0_i.data_b),
      .copy_1_i(exec_in_1_i.data_b), .copy_2_i(exec_in_2_i.data_b),
      .voted_o(voted.data_b), .mismatch_o(mm_v[2]), .fatal_o(fatal_v[2])
   );

   tmr_voter #(.WIDTH(`RSV_CTRL_W)) u_control (
      .secure_mode_i(secure_mode_i), .copy_0_i(exec_in_0_i.control_signals),
      .copy_1_i(exec_in_1_i.control_signals), .copy_2_i(exec_in_2_i.control_signals),
      .voted_o(voted.control_signals), .mismatch_o(mm_v[3]), .fatal_o(fatal_v[3])
   );

   tmr_voter #(.WIDTH(`RSV_PREG_W)) u_rd_phys_addr (
      .secure_mode_i(secure_mode_i), .copy_0_i(exec_in_0_i.rd_phys_addr),
      .copy_1_i(exec_in_1_i.rd_phys_addr), .copy_2_i(exec_in_2_i.rd_phys_addr),
      .voted_o(voted.rd_phys_addr), .mismatch_o(mm_v[4]), .fatal_o(fatal_v[4])
   );

   tmr_voter #(.WIDTH(`RSV_DATA_W)) u_pc (
      .secure_mode_i(secure_mode_i), .copy_0_i(exec_in_0_i.pc),
      .copy_1_i(exec_in_1_i.pc), .copy_2_i(exec_in_2_i.pc),
      .voted_o(voted.pc), .mismatch_o(mm_v[5]), .fatal_o(fatal_v[5])
   );

   tmr_voter #(.WIDTH(`RSV_DATA_W)) u_pc_pred (
      .secure_mode_i(secure_mode_i), .copy_0_i(exec_in_0_i.pc_value_at_prediction),
      .copy_1_i(exec_in_1_i.pc_value_at_prediction),
      .copy_2_i(exec_in_2_i.pc_value_at_prediction),
      .voted_o(voted.pc_value_at_prediction), .mismatch_o(mm_v[6]), .fatal_o(fatal_v[6])
   );

   tmr_voter #(.WIDTH(`RSV_BSEL_W)) u_branch_sel (
      .secure_mode_i(secure_mode_i), .copy_0_i(exec_in_0_i.branch_sel),
      .copy_1_i(exec_in_1_i.branch_sel), .copy_2_i(exec_in_2_i.branch_sel),
      .voted_o(voted.branch_sel), .mismatch_o(mm_v[7]), .fatal_o(fatal_v[7])
   );

   tmr_voter #(.WIDTH(1)) u_branch_pred (
      .secure_mode_i(secure_mode_i), .copy_0_i(exec_in_0_i.branch_prediction),
      .copy_1_i(exec_in_1_i.branch_prediction), .copy_2_i(exec_in_2_i.branch_prediction),
      .voted_o(voted.branch_prediction), .mismatch_o(mm_v[8]), .fatal_o(fatal_v[8])
   );

   tmr_voter #(.WIDTH(`RSV_DATA_W)) u_store_data (
      .secure_mode_i(secure_mode_i), .copy_0_i(exec_in_0_i.store_data),
      .copy_1_i(exec_in_1_i.store_data), .copy_2_i(exec_in_2_i.store_data),
      .voted_o(voted.store_data), .mismatch_o(mm_v[9]), .fatal_o(fatal_v[9])
   );

   // ==================
   // Output routing
   // ==================

   // Secure mode sends the same voted issue to all three execute ports
   assign exec_out_0_o = secure_mode_i ? voted : exec_in_0_i;
   assign exec_out_1_o = secure_mode_i ? voted : exec_in_1_i;
   assign exec_out_2_o = secure_mode_i ? voted : exec_in_2_i;

   assign mismatch_o = |mm_v;
   assign fatal_o    = |fatal_v;

endmodule

`default_nettype wire

//--- rtl/rs_state_vote.sv
`timescale 1ns/1ps
`default_nettype none

`include "rs_validator_cfg.svh"

// Votes the internal register record of the three RS copies
module rs_state_vote (
   input  wire logic                          secure_mode_i,
   input  wire rs_validator_pkg::rs_internal_t rs_state_0_i,
   input  wire rs_validator_pkg::rs_internal_t rs_state_1_i,
   input  wire rs_validator_pkg::rs_internal_t rs_state_2_i,
   output rs_validator_pkg::rs_internal_t      validated_o,
   output logic                               mismatch_o,
   output logic                               fatal_o
);

   // Bit 0 is the enable field, which also counts toward the flags
   logic [12:0] mm_v;
   logic [12:0] fatal_v;

   // ==================
   // Control state
   // ==================

   tmr_voter #(.WIDTH(1)) u_enable (
      .secure_mode_i(secure_mode_i), .copy_0_i(rs_state_0_i.enable),
      .copy_1_i(rs_state_1_i.enable), .copy_2_i(rs_state_2_i.enable),
      .voted_o(validated_o.enable), .mismatch_o(mm_v[0]), .fatal_o(fatal_v[0])
   );

   tmr_voter #(.WIDTH(1)) u_occupied (
      .secure_mode_i(secure_mode_i), .copy_0_i(rs_state_0_i.occupied),
      .copy_1_i(rs_state_1_i.occupied), .copy_2_i(rs_state_2_i.occupied),
      .voted_o(validated_o.occupied), .mismatch_o(mm_v[1]), .fatal_o(fatal_v[1])
   );

   tmr_voter #(.WIDTH(`RSV_CTRL_W)) u_control (
      .secure_mode_i(secure_mode_i), .copy_0_i(rs_state_0_i.control_signals),
      .copy_1_i(rs_state_1_i.control_signals), .copy_2_i(rs_state_2_i.control_signals),
      .voted_o(validated_o.control_signals), .mismatch_o(mm_v[2]), .fatal_o(fatal_v[2])
   );

   tmr_voter #(.WIDTH(`RSV_DATA_W)) u_pc (
      .secure_mode_i(secure_mode_i), .copy_0_i(rs_state_0_i.pc),
      .copy_1_i(rs_state_1_i.pc), .copy_2_i(rs_state_2_i.pc),
      .voted_o(validated_o.pc), .mismatch_o(mm_v[3]), .fatal_o(fatal_v[3])
   );

   tmr_voter #(.WIDTH(`RSV_PREG_W)) u_rd_phys_addr (
      .secure_mode_i(secure_mode_i), .copy_0_i(rs_state_0_i.rd_phys_addr),
      .copy_1_i(rs_state_1_i.rd_phys_addr), .copy_2_i(rs_state_2_i.rd_phys_addr),
      .voted_o(validated_o.rd_phys_addr), .mismatch_o(mm_v[4]), .fatal_o(fatal_v[4])
   );

   tmr_voter #(.WIDTH(`RSV_DATA_W)) u_pc_pred (
      .secure_mode_i(secure_mode_i), .copy_0_i(rs_state_0_i.pc_value_at_prediction),
      .copy_1_i(rs_state_1_i.pc_value_at_prediction),
      .copy_2_i(rs_state_2_i.pc_value_at_prediction),
      .voted_o(validated_o.pc_value_at_prediction),
      .mismatch_o(mm_v[5]), .fatal_o(fatal_v[5])
   );

   tmr_voter #(.WIDTH(`RSV_BSEL_W)) u_branch_sel (
      .secure_mode_i(secure_mode_i), .copy_0_i(rs_state_0_i.branch_sel),
      .copy_1_i(rs_state_1_i.branch_sel), .copy_2_i(rs_state_2_i.branch_sel),
      .voted_o(validated_o.branch_sel), .mismatch_o(mm_v[6]), .fatal_o(fatal_v[6])
   );

   tmr_voter #(.WIDTH(1)) u_branch_pred (
      .secure_mode_i(secure_mode_i), .copy_0_i(rs_state_0_i.branch_prediction),
      .copy_1_i(rs_state_1_i.branch_prediction), .copy_2_i(rs_state_2_i.branch_prediction),
      .voted_o(validated_o.branch_prediction), .mismatch_o(mm_v[7]), .fatal_o(fatal_v[7])
   );

   // ==================
   // Payload state
   // ==================

   tmr_voter #(.WIDTH(`RSV_DATA_W)) u_store_data (
      .secure_mode_i(secure_mode_i), .copy_0_i(rs_state_0_i.store_data),
      .copy_1_i(rs_state_1_i.store_data), .copy_2_i(rs_state_2_i.store_data),
      .voted_o(validated_o.store_data), .mismatch_o(mm_v[8]), .fatal_o(fatal_v[8])
   );

   tmr_voter #(.WIDTH(`RSV_DATA_W)) u_operand_a_data (
      .secure_mode_i(secure_mode_i), .copy_0_i(rs_state_0_i.operand_a_data),
      .copy_1_i(rs_state_1_i.operand_a_data), .copy_2_i(rs_state_2_i.operand_a_data),
      .voted_o(validated_o.operand_a_data), .mismatch_o(mm_v[9]), .fatal_o(fatal_v[9])
   );

   tmr_voter #(.WIDTH(`RSV_TAG_W)) u_operand_a_tag (
      .secure_mode_i(secure_mode_i), .copy_0_i(rs_state_0_i.operand_a_tag),
      .copy_1_i(rs_state_1_i.operand_a_tag), .copy_2_i(rs_state_2_i.operand_a_tag),
      .voted_o(validated_o.operand_a_tag), .mismatch_o(mm_v[10]), .fatal_o(fatal_v[10])
   );

   tmr_voter #(.WIDTH(`RSV_DATA_W)) u_operand_b_data (
      .secure_mode_i(secure_mode_i), .copy_0_i(rs_state_0_i.operand_b_data),
      .copy_1_i(rs_state_1_i.operand_b_data), .copy_2_i(rs_state_2_i.operand_b_data),
      .voted_o(validated_o.operand_b_data), .mismatch_o(mm_v[11]), .fatal_o(fatal_v[11])
   );

   tmr_voter #(.WIDTH(`RSV_TAG_W)) u_operand_b_tag (
      .secure_mode_i(secure_mode_i), .copy_0_i(rs_state_0_i.operand_b_tag),
      .copy_1_i(rs_state_1_i.operand_b_tag), .copy_2_i(rs_state_2_i.operand_b_tag),
      .voted_o(validated_o.operand_b_tag), .mismatch_o(mm_v[12]), .fatal_o(fatal_v[12])
   );

   assign mismatch_o = |mm_v;
   assign fatal_o    = |fatal_v;

endmodule

`default_nettype wire

//--- rtl/rs_validator.sv
`timescale 1ns/1ps
`default_nettype none

// TMR validator for three reservation station copies
module rs_validator (
   input  wire logic                             clk_i,
   input  wire logic                             rst_i,
   input  wire logic                             secure_mode_i,
   input  wire rs_validator_pkg::rs_exec_bundle_t exec_in_0_i,
   input  wire rs_validator_pkg::rs_exec_bundle_t exec_in_1_i,
   input  wire rs_validator_pkg::rs_exec_bundle_t exec_in_2_i,
   input  wire rs_validator_pkg::rs_internal_t    rs_state_0_i,
   input  wire rs_validator_pkg::rs_internal_t    rs_state_1_i,
   input  wire rs_validator_pkg::rs_internal_t    rs_state_2_i,
   output rs_validator_pkg::rs_exec_bundle_t      exec_out_0_o,
   output rs_validator_pkg::rs_exec_bundle_t      exec_out_1_o,
   output rs_validator_pkg::rs_exec_bundle_t      exec_out_2_o,
   output rs_validator_pkg::rs_internal_t         rs_state_validated_o,
   output logic                                  exec_mismatch_o,
   output logic                                  exec_fatal_o,
   output logic                                  internal_mismatch_o,
   output logic                                  internal_fatal_o
);

   // Unregistered flags straight out of the voting blocks
   logic exec_mismatch;
   logic exec_fatal;
   logic internal_mismatch;
   logic internal_fatal;

   // ==================
   // Voting blocks
   // ==================

   exec_vote i_exec_vote (
      .secure_mode_i (secure_mode_i),
      .exec_in_0_i   (exec_in_0_i),
      .exec_in_1_i   (exec_in_1_i),
      .exec_in_2_i   (exec_in_2_i),
      .exec_out_0_o  (exec_out_0_o),
      .exec_out_1_o  (exec_out_1_o),
      .exec_out_2_o  (exec_out_2_o),
      .mismatch_o    (exec_mismatch),
      .fatal_o       (exec_fatal)
   );

   // One validated record goes back to every RS copy
   rs_state_vote i_rs_state_vote (
      .secure_mode_i (secure_mode_i),
      .rs_state_0_i  (rs_state_0_i),
      .rs_state_1_i  (rs_state_1_i),
      .rs_state_2_i  (rs_state_2_i),
      .validated_o   (rs_state_validated_o),
      .mismatch_o    (internal_mismatch),
      .fatal_o       (internal_fatal)
   );

   // ==================
   // Flag registers
   // ==================

   // Flags lag the voted data by one cycle
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         exec_mismatch_o     <= 1'b0;
         exec_fatal_o        <= 1'b0;
         internal_mismatch_o <= 1'b0;
         internal_fatal_o    <= 1'b0;
      end else begin
         exec_mismatch_o     <= exec_mismatch;
         exec_fatal_o        <= exec_fatal;
         internal_mismatch_o <= internal_mismatch;
         internal_fatal_o    <= internal_fatal;
      end
   end

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

// Free-running clock and power-on reset for the testbench
module tb_clock_gen (
   output logic clk_o,
   output logic rst_o
);

   localparam int PERIOD_NS    = 100;
   localparam int RESET_CYCLES = 4;

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

   // Reset drops shortly after the last reset edge, like any other input
   initial begin
      rst_o = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk_o);
      #1;
      rst_o <= 1'b0;
   end

endmodule

`default_nettype wire

//--- verification/tb_rs_validator.sv
`timescale 1ns/1ps
`default_nettype none

`include "rs_validator_cfg.svh"

module tb_rs_validator;

   localparam int EDGE_TIMEOUT_NS      = 200;
   localparam int RESET_TIMEOUT_CYCLES = 20;

   logic clk;
   logic rst;
   logic secure_mode;

   rs_validator_pkg::rs_exec_bundle_t exec_in [3];
   rs_validator_pkg::rs_internal_t    state_in [3];
   rs_validator_pkg::rs_exec_bundle_t exec_out_0;
   rs_validator_pkg::rs_exec_bundle_t exec_out_1;
   rs_validator_pkg::rs_exec_bundle_t exec_out_2;
   rs_validator_pkg::rs_internal_t    validated;

   logic exec_mismatch;
   logic exec_fatal;
   logic internal_mismatch;
   logic internal_fatal;

   // Exec mismatch, exec fatal, internal mismatch, internal fatal
   logic [3:0] flags;

   int unsigned edge_count = 0;
   string       test_name  = "reset";

   assign flags = {exec_mismatch, exec_fatal, internal_mismatch, internal_fatal};

   tb_clock_gen i_tb_clock_gen (
      .clk_o (clk),
      .rst_o (rst)
   );

   rs_validator i_rs_validator (
      .clk_i                (clk),
      .rst_i                (rst),
      .secure_mode_i        (secure_mode),
      .exec_in_0_i          (exec_in[0]),
      .exec_in_1_i          (exec_in[1]),
      .exec_in_2_i          (exec_in[2]),
      .rs_state_0_i         (state_in[0]),
      .rs_state_1_i         (state_in[1]),
      .rs_state_2_i         (state_in[2]),
      .exec_out_0_o         (exec_out_0),
      .exec_out_1_o         (exec_out_1),
      .exec_out_2_o         (exec_out_2),
      .rs_state_validated_o (validated),
      .exec_mismatch_o      (exec_mismatch),
      .exec_fatal_o         (exec_fatal),
      .internal_mismatch_o  (internal_mismatch),
      .internal_fatal_o     (internal_fatal)
   );

   always @(posedge clk) edge_count <= edge_count + 1;

   // ==================
   // Reporting
   // ==================

   task automatic stop_run();
      $display("Test failures found");
      $fatal(1);
   endtask

   task automatic report_problem(string msg);
      $display("%s: %s", test_name, msg);
      stop_run();
   endtask

   task automatic check_exec(string what, rs_validator_pkg::rs_exec_bundle_t exp,
                             rs_validator_pkg::rs_exec_bundle_t act);
      assert (act == exp) else begin
         $display("error: %s %s expected %h actual %h", test_name, what, exp, act);
         stop_run();
      end
   endtask

   task automatic check_state(string what, rs_validator_pkg::rs_internal_t exp,
                              rs_validator_pkg::rs_internal_t act);
      assert (act == exp) else begin
         $display("error: %s %s expected %h actual %h", test_name, what, exp, act);
         stop_run();
      end
   endtask

   task automatic check_flags(logic [3:0] exp);
      assert (flags == exp) else begin
         $display("error: %s flags expected %b actual %b", test_name, exp, flags);
         stop_run();
      end
   endtask

   // Flags registered during reset must come out clear
   flags_clear_after_reset: assert property (
      @(posedge clk) edge_count == 0 || !$past(rst) || flags == 4'b0000
   ) else begin
      $display("error: reset flags expected 0000 actual %b", flags);
      stop_run();
   end

   // Voting off in a cycle means no flag in the next one
   flags_quiet_in_normal_mode: assert property (
      @(posedge clk) disable iff (rst) $past(secure_mode) || flags == 4'b0000
   ) else begin
      $display("error: normal mode flags expected 0000 actual %b", flags);
      stop_run();
   end

   // ==================
   // Stimulus helpers
   // ==================

   // Returns 1 ns after the next rising edge
   task automatic next_cycle();
      int unsigned start;
      int          waited;
      start  = edge_count;
      waited = 0;
      while (edge_count == start && waited < EDGE_TIMEOUT_NS) begin
         #1;
         waited++;
      end
      if (edge_count == start) begin
         report_problem("clock edge did not arrive in time");
      end
   endtask

   task automatic wait_reset_done();
      int cycles;
      cycles = 0;
      while (rst && cycles < RESET_TIMEOUT_CYCLES) begin
         next_cycle();
         check_flags(4'b0000);
         cycles++;
      end
      if (rst) begin
         report_problem("reset was never released");
      end
   endtask

   function automatic rs_validator_pkg::rs_exec_bundle_t random_exec();
      logic [191:0] v;
      v = {$urandom, $urandom, $urandom, $urandom, $urandom, $urandom};
      return v[$bits(rs_validator_pkg::rs_exec_bundle_t)-1:0];
   endfunction

   function automatic rs_validator_pkg::rs_internal_t random_state();
      logic [191:0] v;
      v = {$urandom, $urandom, $urandom, $urandom, $urandom, $urandom};
      return v[$bits(rs_validator_pkg::rs_internal_t)-1:0];
   endfunction

   // XOR one field with the low bits of the mask
   function automatic rs_validator_pkg::rs_exec_bundle_t flip_exec_field(
      rs_validator_pkg::rs_exec_bundle_t b, int f, logic [31:0] m);
      rs_validator_pkg::rs_exec_bundle_t r;
      r = b;
      case (f)
         0: r.issue_valid = r.issue_valid ^ m[0];
         1: r.data_a = r.data_a ^ m[`RSV_DATA_W-1:0];
         2: r.data_b = r.data_b ^ m[`RSV_DATA_W-1:0];
         3: r.control_signals = r.control_signals ^ m[`RSV_CTRL_W-1:0];
         4: r.rd_phys_addr = r.rd_phys_addr ^ m[`RSV_PREG_W-1:0];
         5: r.pc = r.pc ^ m[`RSV_DATA_W-1:0];
         6: r.pc_value_at_prediction = r.pc_value_at_prediction ^ m[`RSV_DATA_W-1:0];
         7: r.branch_sel = r.branch_sel ^ m[`RSV_BSEL_W-1:0];
         8: r.branch_prediction = r.branch_prediction ^ m[0];
         default: r.store_data = r.store_data ^ m[`RSV_DATA_W-1:0];
      endcase
      return r;
   endfunction

   function automatic rs_validator_pkg::rs_internal_t flip_state_field(
      rs_validator_pkg::rs_internal_t s, int f, logic [31:0] m);
      rs_validator_pkg::rs_internal_t r;
      r = s;
      case (f)
         0: r.enable = r.enable ^ m[0];
         1: r.occupied = r.occupied ^ m[0];
         2: r.control_signals = r.control_signals ^ m[`RSV_CTRL_W-1:0];
         3: r.pc = r.pc ^ m[`RSV_DATA_W-1:0];
         4: r.rd_phys_addr = r.rd_phys_addr ^ m[`RSV_PREG_W-1:0];
         5: r.pc_value_at_prediction = r.pc_value_at_prediction ^ m[`RSV_DATA_W-1:0];
         6: r.branch_sel = r.branch_sel ^ m[`RSV_BSEL_W-1:0];
         7: r.branch_prediction = r.branch_prediction ^ m[0];
         8: r.store_data = r.store_data ^ m[`RSV_DATA_W-1:0];
         9: r.operand_a_data = r.operand_a_data ^ m[`RSV_DATA_W-1:0];
         10: r.operand_a_tag = r.operand_a_tag ^ m[`RSV_TAG_W-1:0];
         11: r.operand_b_data = r.operand_b_data ^ m[`RSV_DATA_W-1:0];
         default: r.operand_b_tag = r.operand_b_tag ^ m[`RSV_TAG_W-1:0];
      endcase
      return r;
   endfunction

   task automatic load_copies(rs_validator_pkg::rs_exec_bundle_t b,
                              rs_validator_pkg::rs_internal_t s);
      for (int i = 0; i < 3; i++) begin
         exec_in[i]  = b;
         state_in[i] = s;
      end
   endtask

   task automatic check_all_exec(rs_validator_pkg::rs_exec_bundle_t exp);
      check_exec("exec_out_0", exp, exec_out_0);
      check_exec("exec_out_1", exp, exec_out_1);
      check_exec("exec_out_2", exp, exec_out_2);
   endtask

   // ==================
   // Tests
   // ==================

   task automatic run_normal_mode();
      test_name   = "normal_mode";
      secure_mode = 1'b0;
      for (int n = 0; n < 8; n++) begin
         for (int i = 0; i < 3; i++) begin
            exec_in[i]  = random_exec();
            state_in[i] = random_state();
         end
         next_cycle();
         check_exec("exec_out_0", exec_in[0], exec_out_0);
         check_exec("exec_out_1", exec_in[1], exec_out_1);
         check_exec("exec_out_2", exec_in[2], exec_out_2);
         check_state("validated", state_in[0], validated);
         check_flags(4'b0000);
      end
   endtask

   task automatic run_all_agree();
      rs_validator_pkg::rs_exec_bundle_t b;
      rs_validator_pkg::rs_internal_t    s;
      test_name   = "all_agree";
      secure_mode = 1'b1;
      for (int n = 0; n < 8; n++) begin
         b = random_exec();
         s = random_state();
         load_copies(b, s);
         next_cycle();
         check_all_exec(b);
         check_state("validated", s, validated);
         check_flags(4'b0000);
      end
   endtask

   // The majority is the clean value whichever copy was hit
   task automatic run_single_corruption();
      rs_validator_pkg::rs_exec_bundle_t b;
      rs_validator_pkg::rs_internal_t    s;
      int                                f;
      int                                victim;
      logic [31:0]                       m;
      logic [3:0]                        exp_flags;
      logic [3:0]                        prev_flags;
      test_name   = "single_corruption";
      secure_mode = 1'b1;
      prev_flags  = 4'b0000;
      for (int n = 0; n < 24; n++) begin
         b = random_exec();
         s = random_state();
         load_copies(b, s);
         victim = $urandom % 3;
         m      = $urandom | 32'd1;
         if (n % 2 == 0) begin
            f               = $urandom % 10;
            exec_in[victim] = flip_exec_field(exec_in[victim], f, m);
         end else begin
            f                = $urandom % 13;
            state_in[victim] = flip_state_field(state_in[victim], f, m);
         end
         // Registered flags still show the previous inputs
         #1;
         check_flags(prev_flags);
         next_cycle();
         exp_flags = (n % 2 == 0) ? 4'b1000 : 4'b0010;
         check_all_exec(b);
         check_state("validated", s, validated);
         check_flags(exp_flags);
         prev_flags = exp_flags;
      end
   endtask

   // Copies 0 and 1 differ in bit 1, both differ from copy 2 in bit 0
   task automatic run_triple_disagreement();
      rs_validator_pkg::rs_exec_bundle_t b;
      rs_validator_pkg::rs_internal_t    s;
      int                                f;
      logic [31:0]                       m;
      test_name   = "triple_disagreement";
      secure_mode = 1'b1;
      for (int n = 0; n < 16; n++) begin
         b = random_exec();
         s = random_state();
         load_copies(b, s);
         m = $urandom | 32'd1;
         if (n % 2 == 0) begin
            // Only multi-bit fields can hold three distinct values
            f = 1 + $urandom % 8;
            if (f == 8) begin
               f = 9;
            end
            exec_in[0] = flip_exec_field(b, f, m);
            exec_in[1] = flip_exec_field(b, f, m ^ 32'd2);
         end else begin
            f = 2 + $urandom % 10;
            if (f >= 7) begin
               f++;
            end
            state_in[0] = flip_state_field(s, f, m);
            state_in[1] = flip_state_field(s, f, m ^ 32'd2);
         end
         next_cycle();
         check_all_exec(exec_in[0]);
         check_state("validated", state_in[0], validated);
         check_flags((n % 2 == 0) ? 4'b1100 : 4'b0011);
      end
   endtask

   initial begin
      void'($urandom(32'hc1e4_f3b7));
      // Disagreeing copies in secure mode, so only reset keeps the flags clear
      secure_mode = 1'b1;
      for (int i = 0; i < 3; i++) begin
         exec_in[i]  = random_exec();
         state_in[i] = random_state();
      end
      next_cycle();
      check_flags(4'b0000);
      secure_mode = 1'b0;
      for (int i = 0; i < 3; i++) begin
         exec_in[i]  = '0;
         state_in[i] = '0;
      end
      wait_reset_done();
      run_normal_mode();
      run_all_agree();
      run_single_corruption();
      run_triple_disagreement();
      $display("All tests passed!");
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+include
rtl/rs_validator_pkg.sv
rtl/tmr_voter.sv
rtl/exec_vote.sv
rtl/rs_state_vote.sv
rtl/rs_validator.sv
verification/tb_clock_gen.sv
verification/tb_rs_validator.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert \
   --top-module tb_rs_validator \
   -f verilog.f \
   -o tb_rs_validator_sim

# The log decides the verdict, so the run itself may return non-zero
./obj_dir/tb_rs_validator_sim 2>&1 | tee sim.log

if grep -qF 'All tests passed!' sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed, see sim.log"
   exit 1
fi
